/* rtl/axi_lite_pkg.sv */
package axi_lite_pkg;

  // bus widths fixed by the board
  localparam int axi_addr_bits = 20;
  localparam int axi_data_bits = 16;
  localparam int axi_strb_bits = 2;

  // response codes
  localparam logic [1:0] resp_okay   = 2'b00;
  localparam logic [1:0] resp_slverr = 2'b10;

  // write address and data accepted together
  typedef struct packed {
    logic [axi_addr_bits-1:0] awaddr;
    logic [axi_data_bits-1:0] wdata;
    logic [axi_strb_bits-1:0] wstrb;
  } axi_wr_req_t;

  // read data channel payload
  typedef struct packed {
    logic [axi_data_bits-1:0] rdata;
    logic [1:0]               rresp;
  } axi_rd_resp_t;

endpackage

/* rtl/axi_sram_controller.sv */
`timescale 1ns/1ps

module axi_sram_controller (
  input  logic                                   axi_clk,
  input  logic                                   axi_resetn,

  // write address and data handshaken together
  input  axi_lite_pkg::axi_wr_req_t              wr_req,
  input  logic                                   awvalid,
  input  logic                                   wvalid,
  output logic                                   awready,
  output logic                                   wready,

  // write response
  output logic [1:0]                             bresp,
  output logic                                   bvalid,
  input  logic                                   bready,

  // read address
  input  logic [axi_lite_pkg::axi_addr_bits-1:0] araddr,
  input  logic                                   arvalid,
  output logic                                   arready,

  // read data
  output axi_lite_pkg::axi_rd_resp_t             rd_resp,
  output logic                                   rvalid,
  input  logic                                   rready,

  // sram chip
  output sram_pkg::sram_pins_t                   sram_pins,
  inout  wire  [sram_pkg::sram_data_bits-1:0]    sram_data
);
  import axi_lite_pkg::*;
  import sram_pkg::*;

  typedef enum logic [2:0] {
    st_idle,
    st_write_wait,
    st_write_resp,
    st_read_wait,
    st_read_resp
  } state_t;

  state_t                    state;
  logic                      wr_pending;
  logic                      rd_pending;
  logic                      grant_wr;
  logic                      grant_rd;
  logic                      strobe_ok;
  logic                      seq_req;
  sram_req_t                 seq_cmd;
  logic                      write_done;
  logic                      read_valid;
  logic [sram_data_bits-1:0] read_data;

  // only offer requests to the arbiter while idle
  assign wr_pending = (state == st_idle) && awvalid && wvalid;
  assign rd_pending = (state == st_idle) && arvalid;

  rw_arbiter arb0 (
    .axi_clk    (axi_clk),
    .axi_resetn (axi_resetn),
    .wr_pending (wr_pending),
    .rd_pending (rd_pending),
    .grant_wr   (grant_wr),
    .grant_rd   (grant_rd)
  );

  // handshake happens in the grant cycle
  assign awready = grant_wr;
  assign wready  = grant_wr;
  assign arready = grant_rd;

  // byte lanes are not wired on the chip
  assign strobe_ok = &wr_req.wstrb;

  assign seq_req              = (grant_wr && strobe_ok) || grant_rd;
  assign seq_cmd.write_enable = grant_wr;
  assign seq_cmd.addr         = grant_wr ? wr_req.awaddr : araddr;
  assign seq_cmd.write_data   = wr_req.wdata;

  sram_controller seq0 (
    .axi_clk    (axi_clk),
    .axi_resetn (axi_resetn),
    .req        (seq_req),
    .cmd        (seq_cmd),
    .write_done (write_done),
    .read_valid (read_valid),
    .read_data  (read_data),
    .pins       (sram_pins),
    .data_io    (sram_data)
  );

  // transaction FSM with valid flags
  always_ff @(posedge axi_clk) begin
    if (!axi_resetn) begin
      state  <= st_idle;
      bvalid <= 1'b0;
      rvalid <= 1'b0;
    end else begin
      case (state)
        st_idle: begin
          if (grant_wr) begin
            // rejected writes skip the sram entirely
            state <= strobe_ok ? st_write_wait : st_write_resp;
          end else if (grant_rd) begin
            state <= st_read_wait;
          end
        end
        st_write_wait: begin
          if (write_done) begin
            state  <= st_write_resp;
            bvalid <= 1'b1;
          end
        end
        st_write_resp: begin
          // slverr path arrives here with bvalid still low
          if (!bvalid) begin
            bvalid <= 1'b1;
          end else if (bready) begin
            bvalid <= 1'b0;
            state  <= st_idle;
          end
        end
        st_read_wait: begin
          if (read_valid) begin
            state  <= st_read_resp;
            rvalid <= 1'b1;
          end
        end
        st_read_resp: begin
          if (rready) begin
            rvalid <= 1'b0;
            state  <= st_idle;
          end
        end
        default: state <= st_idle;
      endcase
    end
  end

  // response payload held until the handshake
  always_ff @(posedge axi_clk) begin
    if (grant_wr) begin
      bresp <= strobe_ok ? resp_okay : resp_slverr;
    end
    if (state == st_read_wait && read_valid) begin
      rd_resp.rdata <= read_data;
      rd_resp.rresp <= resp_okay;
    end
  end

endmodule

/* rtl/rw_arbiter.sv */
`timescale 1ns/1ps

module rw_arbiter (
  input  logic axi_clk,
  input  logic axi_resetn,
  input  logic wr_pending,
  input  logic rd_pending,
  output logic grant_wr,
  output logic grant_rd
);

  // high when writes win a tie
  logic pri_wr;

  always_comb begin
    grant_wr = 1'b0;
    grant_rd = 1'b0;
    if (wr_pending && rd_pending) begin
      if (pri_wr) begin
        grant_wr = 1'b1;
      end else begin
        grant_rd = 1'b1;
      end
    end else begin
      // lone request always wins
      grant_wr = wr_pending;
      grant_rd = rd_pending;
    end
  end

  // flip after every grant so neither side starves
  always_ff @(posedge axi_clk) begin
    if (!axi_resetn) begin
      pri_wr <= 1'b0;
    end else if (grant_wr || grant_rd) begin
      pri_wr <= ~pri_wr;
    end
  end

endmodule

/* rtl/sram_controller.sv */
`timescale 1ns/1ps

module sram_controller (
  input  logic                                axi_clk,
  input  logic                                axi_resetn,
  input  logic                                req,
  input  sram_pkg::sram_req_t                 cmd,
  output logic                                write_done,
  output logic                                read_valid,
  output logic [sram_pkg::sram_data_bits-1:0] read_data,
  output sram_pkg::sram_pins_t                pins,
  inout  wire  [sram_pkg::sram_data_bits-1:0] data_io
);
  import sram_pkg::*;

  typedef enum logic [1:0] {
    st_idle,
    st_write,
    st_read
  } state_t;

  state_t                    state;
  logic [2:0]                cycle_cnt;
  logic                      we_n_q;
  logic                      oe_n_q;
  logic                      ce_n_q;
  logic                      drive_q;
  logic [sram_addr_bits-1:0] addr_q;
  logic [sram_data_bits-1:0] wdata_q;

  // strobes and pin levels are all registered
  always_ff @(posedge axi_clk) begin
    if (!axi_resetn) begin
      state      <= st_idle;
      cycle_cnt  <= '0;
      we_n_q     <= 1'b1;
      oe_n_q     <= 1'b1;
      ce_n_q     <= 1'b1;
      drive_q    <= 1'b0;
      write_done <= 1'b0;
      read_valid <= 1'b0;
    end else begin
      write_done <= 1'b0;
      read_valid <= 1'b0;
      case (state)
        st_idle: begin
          if (req) begin
            cycle_cnt <= '0;
            ce_n_q    <= 1'b0;
            if (cmd.write_enable) begin
              state   <= st_write;
              we_n_q  <= 1'b0;
              drive_q <= 1'b1;
            end else begin
              state  <= st_read;
              oe_n_q <= 1'b0;
            end
          end
        end
        st_write: begin
          cycle_cnt <= cycle_cnt + 3'd1;
          // we_n rises a cycle before the data is released
          if (cycle_cnt == 3'(sram_write_cycles - 1)) begin
            we_n_q <= 1'b1;
            ce_n_q <= 1'b1;
          end
          if (cycle_cnt == 3'(sram_write_cycles)) begin
            drive_q    <= 1'b0;
            write_done <= 1'b1;
            state      <= st_idle;
          end
        end
        st_read: begin
          cycle_cnt <= cycle_cnt + 3'd1;
          if (cycle_cnt == 3'(sram_read_cycles - 1)) begin
            oe_n_q <= 1'b1;
            ce_n_q <= 1'b1;
          end
          if (cycle_cnt == 3'(sram_read_cycles)) begin
            read_valid <= 1'b1;
            state      <= st_idle;
          end
        end
        default: state <= st_idle;
      endcase
    end
  end

  // command latch and read capture
  always_ff @(posedge axi_clk) begin
    if (state == st_idle && req) begin
      addr_q  <= cmd.addr;
      wdata_q <= cmd.write_data;
    end
    // sample on the last cycle oe_n is low
    if (state == st_read && cycle_cnt == 3'(sram_read_cycles - 1)) begin
      read_data <= data_io;
    end
  end

  assign pins = '{addr: addr_q, we_n: we_n_q, oe_n: oe_n_q, ce_n: ce_n_q};

  // bus released except while writing
  assign data_io = drive_q ? wdata_q : 'z;

endmodule

/* rtl/sram_pkg.sv */
package sram_pkg;

  // chip geometry
  localparam int sram_addr_bits = 20;
  localparam int sram_data_bits = 16;

  // cycles we_n is held low per write
  localparam int sram_write_cycles = 2;
  // cycles oe_n is held low before sampling
  localparam int sram_read_cycles = 2;

  // one access command
  typedef struct packed {
    logic                      write_enable;
    logic [sram_addr_bits-1:0] addr;
    logic [sram_data_bits-1:0] write_data;
  } sram_req_t;

  // chip outputs other than the data bus
  typedef struct packed {
    logic [sram_addr_bits-1:0] addr;
    logic                      we_n;
    logic                      oe_n;
    logic                      ce_n;
  } sram_pins_t;

endpackage

/* sources.f */
rtl/axi_lite_pkg.sv
rtl/sram_pkg.sv
rtl/sram_controller.sv
rtl/rw_arbiter.sv
rtl/axi_sram_controller.sv
tests/async_sram_model.sv
tests/tb_axi_sram.sv

/* tests/async_sram_model.sv */
`timescale 1ns/1ps

module async_sram_model (
  input  sram_pkg::sram_pins_t                pins,
  inout  wire  [sram_pkg::sram_data_bits-1:0] data
);
  import sram_pkg::*;

  // sparse storage where unwritten words read as zero
  logic [sram_data_bits-1:0] mem [logic [sram_addr_bits-1:0]];
  logic [sram_data_bits-1:0] read_word;
  wire  [sram_addr_bits-1:0] addr = pins.addr;
  wire                       we_n = pins.we_n;
  wire                       oe_n = pins.oe_n;
  wire                       ce_n = pins.ce_n;

  // word committed at the end of the we_n pulse
  always @(posedge we_n) begin
    if (^{addr, data} !== 1'bx) begin
      mem[addr] = data;
    end
  end

  always @(addr or oe_n or ce_n) begin
    if (^addr === 1'bx) begin
      read_word = 'x;
    end else if (mem.exists(addr)) begin
      read_word = mem[addr];
    end else begin
      read_word = '0;
    end
  end

  // chip drives the bus only while selected and output enabled
  assign data = (!ce_n && !oe_n && we_n) ? read_word : 'z;

endmodule

/* tests/tb_axi_sram.sv */
`timescale 1ns/1ps

module tb_axi_sram;
  import axi_lite_pkg::*;
  import sram_pkg::*;

  localparam int n_rw = 200;
  localparam int n_partial = 20;
  localparam int n_fair = 20;
  localparam int cycle_limit = 60 * (n_rw + 2 * n_partial + n_fair) + 100;
  localparam logic [19:0] addr_base = 20'ha5400;

  logic         axi_clk;
  logic         axi_resetn;
  axi_wr_req_t  wr_req;
  logic         awvalid;
  logic         wvalid;
  logic         awready;
  logic         wready;
  logic [1:0]   bresp;
  logic         bvalid;
  logic         bready;
  logic [19:0]  araddr;
  logic         arvalid;
  logic         arready;
  axi_rd_resp_t rd_resp;
  logic         rvalid;
  logic         rready;
  sram_pins_t   sram_pins;
  wire  [15:0]  sram_data;

  // reference memory and expected arbiter priority
  logic [15:0]  ref_mem [logic [19:0]];
  logic         pri_wr;
  logic [19:0]  cur_waddr;
  logic [15:0]  cur_wdata;
  logic [1:0]   cur_wstrb;
  logic [19:0]  cur_raddr;
  int           errors;
  int           err_mark;
  int           pass_count;
  int           fail_count;
  int           cycle_count;

  axi_sram_controller dut0 (.*);

  async_sram_model mem0 (.pins(sram_pins), .data(sram_data));

  initial begin
    axi_clk = 1'b0;
    forever #5 axi_clk = ~axi_clk;
  end

  always @(posedge axi_clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= cycle_limit) begin
      $display("timeout: run still busy after %0d cycles", cycle_limit);
      $display("TESTBENCH FAILED");
      $finish;
    end
  end

  task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] act);
    assert (act === exp) else begin
      $display("[ERROR] %s expected 0x%0h got 0x%0h", name, exp, act);
      errors++;
    end
  endtask

  task automatic finish_test(input string name, input int mark);
    if (errors == mark) begin
      pass_count++;
      $display("test %s: pass", name);
    end else begin
      fail_count++;
      $display("test %s: fail with %0d errors", name, errors - mark);
    end
  endtask

  function automatic logic [19:0] random_addr();
    return addr_base | 20'($urandom_range(63, 0));
  endfunction

  task automatic apply_reset();
    axi_resetn <= 1'b0;
    awvalid    <= 1'b0;
    wvalid     <= 1'b0;
    arvalid    <= 1'b0;
    bready     <= 1'b0;
    rready     <= 1'b0;
    pri_wr = 1'b0;
    repeat (2) @(posedge axi_clk);
    axi_resetn <= 1'b1;
  endtask

  // new payloads are driven from a rising edge
  task automatic load_write(input logic [1:0] strb);
    cur_waddr = random_addr();
    cur_wdata = 16'($urandom);
    cur_wstrb = strb;
    wr_req.awaddr <= cur_waddr;
    wr_req.wdata  <= cur_wdata;
    wr_req.wstrb  <= cur_wstrb;
  endtask

  task automatic load_read(input logic [19:0] addr);
    cur_raddr = addr;
    araddr <= addr;
  endtask

  task automatic check_resp(input bit is_wr, input logic [1:0] exp_resp,
                            input logic [15:0] exp_data);
    if (is_wr) begin
      check_val("bvalid", 1, bvalid);
      check_val("bresp", exp_resp, bresp);
    end else begin
      check_val("rvalid", 1, rvalid);
      check_val("rdata", exp_data, rd_resp.rdata);
      check_val("rresp", exp_resp, rd_resp.rresp);
    end
  endtask

  // serves one grant through its response from falling edge to falling edge
  task automatic serve_grant(input bit hold);
    bit          exp_wr;
    bit          is_wr;
    int          lat;
    int          exp_lat;
    int          stall;
    logic [1:0]  exp_resp;
    logic [15:0] exp_data;
    while (!awready && !arready) @(negedge axi_clk);
    exp_wr = (awvalid && wvalid && arvalid) ? pri_wr : (awvalid && wvalid);
    assert (!(awready && arready)) else begin
      $display("write and read granted in the same cycle");
      errors++;
    end
    check_val("awready", exp_wr, awready);
    check_val("wready", exp_wr, wready);
    check_val("arready", !exp_wr, arready);
    is_wr = awready;
    pri_wr = !pri_wr;
    exp_data = 16'h0;
    exp_resp = resp_okay;
    exp_lat = 4;
    if (is_wr && cur_wstrb == 2'b11) begin
      ref_mem[cur_waddr] = cur_wdata;
    end else if (is_wr) begin
      exp_resp = resp_slverr;
      exp_lat = 1;
    end else if (ref_mem.exists(cur_raddr)) begin
      exp_data = ref_mem[cur_raddr];
    end
    // handshake edge
    @(posedge axi_clk);
    if (hold && is_wr) begin
      load_write(2'b11);
    end else if (hold) begin
      load_read(random_addr());
    end else if (is_wr) begin
      awvalid <= 1'b0;
      wvalid  <= 1'b0;
    end else begin
      arvalid <= 1'b0;
    end
    lat = 0;
    @(negedge axi_clk);
    while (!(is_wr ? bvalid : rvalid)) begin
      @(negedge axi_clk);
      lat++;
    end
    assert (lat == exp_lat) else begin
      $display("response valid rose %0d cycles after handshake, wanted %0d", lat, exp_lat);
      errors++;
    end
    check_resp(is_wr, exp_resp, exp_data);
    stall = $urandom_range(7, 0);
    repeat (stall) begin
      @(negedge axi_clk);
      check_resp(is_wr, exp_resp, exp_data);
    end
    @(posedge axi_clk);
    bready <= is_wr;
    rready <= !is_wr;
    @(negedge axi_clk);
    check_resp(is_wr, exp_resp, exp_data);
    @(posedge axi_clk);
    bready <= 1'b0;
    rready <= 1'b0;
    @(negedge axi_clk);
    assert (!(is_wr ? bvalid : rvalid)) else begin
      $display("response valid stayed high after its handshake");
      errors++;
    end
  endtask

  initial begin
    void'($urandom(20));
    errors = 0;
    pass_count = 0;
    fail_count = 0;
    cycle_count = 0;
    axi_resetn = 1'b0;
    wr_req = '0;
    awvalid = 1'b0;
    wvalid = 1'b0;
    bready = 1'b0;
    araddr = '0;
    arvalid = 1'b0;
    rready = 1'b0;
    apply_reset();

    err_mark = errors;
    @(negedge axi_clk);
    check_val("awready", 0, awready);
    check_val("wready", 0, wready);
    check_val("arready", 0, arready);
    check_val("bvalid", 0, bvalid);
    check_val("rvalid", 0, rvalid);
    check_val("sram_pins.ce_n", 1, sram_pins.ce_n);
    check_val("sram_pins.we_n", 1, sram_pins.we_n);
    check_val("sram_pins.oe_n", 1, sram_pins.oe_n);
    finish_test("reset_state", err_mark);

    err_mark = errors;
    repeat (n_rw) begin
      @(posedge axi_clk);
      if ($urandom_range(1, 0) == 1) begin
        load_write(2'b11);
        awvalid <= 1'b1;
        wvalid  <= 1'b1;
      end else begin
        load_read(random_addr());
        arvalid <= 1'b1;
      end
      @(negedge axi_clk);
      serve_grant(1'b0);
    end
    finish_test("write_read", err_mark);

    // rejected write followed by a read of the old word
    err_mark = errors;
    repeat (n_partial) begin
      @(posedge axi_clk);
      load_write(2'($urandom_range(2, 0)));
      awvalid <= 1'b1;
      wvalid  <= 1'b1;
      @(negedge axi_clk);
      serve_grant(1'b0);
      @(posedge axi_clk);
      load_read(cur_waddr);
      arvalid <= 1'b1;
      @(negedge axi_clk);
      serve_grant(1'b0);
    end
    finish_test("partial_strobe", err_mark);

    // all channels stay valid until the last two rounds drain them
    err_mark = errors;
    @(posedge axi_clk);
    apply_reset();
    load_write(2'b11);
    load_read(random_addr());
    awvalid <= 1'b1;
    wvalid  <= 1'b1;
    arvalid <= 1'b1;
    @(negedge axi_clk);
    for (int i = 0; i < n_fair; i++) begin
      serve_grant(i < n_fair - 2);
    end
    finish_test("fairness", err_mark);

    $display("tests passed %0d failed %0d", pass_count, fail_count);
    if (fail_count == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule
